/* Bender.yml */
package:
  name: operand_collector

sources:
  - source/oc_pkg.sv
  - source/register_banks.sv
  - source/collector_unit.sv
  - source/bank_arbiter.sv
  - source/dispatch_arbiter.sv
  - source/operand_dispatch_mux.sv
  - source/operand_collector.sv
  - target: simulation
    files:
      - dv/tb_operand_collector.sv

/* dv/tb_operand_collector.sv */
`timescale 1ns/10ps

module tb_operand_collector;
    import oc_pkg::*;

    localparam int timeout_cycles = 2000; // 128 register loads plus about 100 test cycles
    localparam int num_regs       = 2 ** reg_aw;
    localparam int num_ids        = 2 ** scb_w;

    logic                clk;
    logic                rst;
    logic                issue_valid;
    logic [warp_w-1:0]   issue_warp;
    logic [instr_w-1:0]  issue_instr;
    logic                issue_reg_write;
    logic [imme_w-1:0]   issue_imme;
    logic                issue_imme_valid;
    alu_op_e             issue_alu_op;
    logic                issue_mem_write;
    logic                issue_mem_read;
    logic [scb_w-1:0]    issue_scb_id;
    logic [mask_w-1:0]   issue_active_mask;
    logic [reg_aw-1:0]   issue_dst;
    logic [reg_aw-1:0]   issue_src0;
    logic [reg_aw-1:0]   issue_src1;
    logic                full;
    logic                wb_en;
    logic [warp_w-1:0]   wb_warp;
    logic [reg_aw-1:0]   wb_reg;
    logic [opnd_w-1:0]   wb_data;
    logic                ex_valid;
    logic [opnd_w-1:0]   oc_0_data;
    logic [opnd_w-1:0]   oc_1_data;
    logic [instr_w-1:0]  ex_instr;
    logic                ex_reg_write;
    logic [imme_w-1:0]   ex_imme;
    logic                ex_imme_valid;
    alu_op_e             ex_alu_op;
    logic                ex_mem_write;
    logic                ex_mem_read;
    logic [scb_w-1:0]    ex_scb_id;
    logic [mask_w-1:0]   ex_active_mask;
    logic [reg_aw-1:0]   ex_dst;

    logic [opnd_w-1:0]   model [num_warps][num_regs]; // mirror of the register file
    logic [opnd_w-1:0]   exp_op0 [num_ids];
    logic [opnd_w-1:0]   exp_op1 [num_ids];
    logic [instr_w-1:0]  exp_instr [num_ids];
    logic [imme_w-1:0]   exp_imme [num_ids];
    logic                exp_imme_valid [num_ids];
    logic                exp_reg_write [num_ids];
    logic                exp_mem_write [num_ids];
    logic                exp_mem_read [num_ids];
    alu_op_e             exp_alu_op [num_ids];
    logic [mask_w-1:0]   exp_mask [num_ids];
    logic [reg_aw-1:0]   exp_dst [num_ids];
    bit                  seen [num_ids]; // set once dispatched, or when nothing is outstanding
    integer              seed;
    int                  cycles = 0;

    operand_collector u_operand_collector (
        .clk               (clk),
        .rst               (rst),
        .issue_valid       (issue_valid),
        .issue_warp        (issue_warp),
        .issue_instr       (issue_instr),
        .issue_reg_write   (issue_reg_write),
        .issue_imme        (issue_imme),
        .issue_imme_valid  (issue_imme_valid),
        .issue_alu_op      (issue_alu_op),
        .issue_mem_write   (issue_mem_write),
        .issue_mem_read    (issue_mem_read),
        .issue_scb_id      (issue_scb_id),
        .issue_active_mask (issue_active_mask),
        .issue_dst         (issue_dst),
        .issue_src0        (issue_src0),
        .issue_src1        (issue_src1),
        .full              (full),
        .wb_en             (wb_en),
        .wb_warp           (wb_warp),
        .wb_reg            (wb_reg),
        .wb_data           (wb_data),
        .ex_valid          (ex_valid),
        .oc_0_data         (oc_0_data),
        .oc_1_data         (oc_1_data),
        .ex_instr          (ex_instr),
        .ex_reg_write      (ex_reg_write),
        .ex_imme           (ex_imme),
        .ex_imme_valid     (ex_imme_valid),
        .ex_alu_op         (ex_alu_op),
        .ex_mem_write      (ex_mem_write),
        .ex_mem_read       (ex_mem_read),
        .ex_scb_id         (ex_scb_id),
        .ex_active_mask    (ex_active_mask),
        .ex_dst            (ex_dst)
    );

    initial
        clk = 1'b0;

    always
        #20 clk = ~clk;

    task automatic abort(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [opnd_w-1:0] actual,
                         input logic [opnd_w-1:0] expected);
        if (actual !== expected)
            abort($sformatf("FAIL at %0t: %s is %h, expected %h", $time, name, actual, expected));
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
            abort($sformatf("Timeout: the run did not end within %0d cycles", timeout_cycles));
    end

    function automatic logic [opnd_w-1:0] random_operand();
        logic [opnd_w-1:0] v;
        for (int i = 0; i < lanes; i++)
            v[i*lane_w +: lane_w] = $random(seed);
        return v;
    endfunction

    task automatic write_reg(input logic [warp_w-1:0] warp, input logic [reg_aw-1:0] r,
                             input logic [opnd_w-1:0] data);
        wb_en   = 1'b1;
        wb_warp = warp;
        wb_reg  = r;
        wb_data = data;
        model[warp][r] = data;
        @(negedge clk);
        wb_en = 1'b0;
    endtask

    task automatic load_registers();
        for (int w = 0; w < num_warps; w++)
            for (int r = 0; r < num_regs; r++)
                write_reg(warp_w'(w), reg_aw'(r), random_operand());
    endtask

    // one-cycle issue strobe with random control fields
    task automatic issue(input logic [warp_w-1:0] warp, input logic [reg_aw-1:0] src0,
                         input logic [reg_aw-1:0] src1, input logic imm,
                         input logic [scb_w-1:0] id);
        logic [31:0] r;
        logic [31:0] m;
        r = $random(seed);
        m = $random(seed);
        check("full", full, 1'b0);
        issue_valid       = 1'b1;
        issue_warp        = warp;
        issue_src0        = src0;
        issue_src1        = src1;
        issue_imme_valid  = imm;
        issue_scb_id      = id;
        issue_instr       = $random(seed);
        issue_imme        = r[15:0];
        issue_alu_op      = alu_op_e'({1'b0, r[18:16]});
        issue_reg_write   = r[19];
        issue_mem_write   = r[20];
        issue_mem_read    = r[21];
        issue_dst         = r[26:22];
        issue_active_mask = m[7:0];
        exp_op0[id]        = model[warp][src0];
        exp_op1[id]        = imm ? '0 : model[warp][src1]; // src1 unused with an immediate
        exp_instr[id]      = issue_instr;
        exp_imme[id]       = issue_imme;
        exp_imme_valid[id] = imm;
        exp_alu_op[id]     = issue_alu_op;
        exp_reg_write[id]  = issue_reg_write;
        exp_mem_write[id]  = issue_mem_write;
        exp_mem_read[id]   = issue_mem_read;
        exp_dst[id]        = issue_dst;
        exp_mask[id]       = issue_active_mask;
        seen[id]           = 1'b0;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic check_dispatch();
        int id;
        id = ex_scb_id;
        if (seen[id])
            abort($sformatf("Unexpected dispatch of scb_id %0d at %0t", id, $time));
        else
        begin
            seen[id] = 1'b1;
            check("oc_0_data", oc_0_data, exp_op0[id]);
            check("oc_1_data", oc_1_data, exp_op1[id]);
            check("ex_instr", ex_instr, exp_instr[id]);
            check("ex_imme", ex_imme, exp_imme[id]);
            check("ex_imme_valid", ex_imme_valid, exp_imme_valid[id]);
            check("ex_alu_op", ex_alu_op, exp_alu_op[id]);
            check("ex_reg_write", ex_reg_write, exp_reg_write[id]);
            check("ex_mem_write", ex_mem_write, exp_mem_write[id]);
            check("ex_mem_read", ex_mem_read, exp_mem_read[id]);
            check("ex_dst", ex_dst, exp_dst[id]);
            check("ex_active_mask", ex_active_mask, exp_mask[id]);
        end
    endtask

    task automatic collect(input int n);
        repeat (n)
        begin
            while (!ex_valid)
                @(negedge clk);
            check_dispatch();
            @(negedge clk);
        end
        check("ex_valid", ex_valid, 1'b0); // nothing left in flight
    endtask

    task automatic test_reset();
        check("ex_valid", ex_valid, 1'b0);
        check("full", full, 1'b0);
    endtask

    task automatic test_single();
        issue(2'd1, 5'd4, 5'd9, 1'b0, 2'd0); // even and odd bank
        collect(1);
    endtask

    task automatic test_immediate();
        issue(2'd3, 5'd11, 5'd20, 1'b1, 2'd1);
        collect(1);
    endtask

    task automatic test_same_bank();
        issue(2'd0, 5'd2, 5'd6, 1'b0, 2'd2);
        collect(1);
        issue(2'd2, 5'd7, 5'd7, 1'b0, 2'd3); // same register twice
        collect(1);
    endtask

    task automatic test_full();
        issue(2'd0, 5'd1, 5'd2, 1'b0, 2'd0);
        issue(2'd1, 5'd3, 5'd3, 1'b0, 2'd1);
        issue(2'd2, 5'd8, 5'd10, 1'b0, 2'd2);
        issue(2'd3, 5'd5, 5'd14, 1'b1, 2'd3);
        check("full", full, 1'b1);
        while (!ex_valid)
            @(negedge clk);
        check("full", full, 1'b1);
        check_dispatch();
        @(negedge clk);
        check("full", full, 1'b0); // first slot freed
        collect(3);
    endtask

    task automatic test_write_then_read();
        write_reg(2'd2, 5'd9, random_operand());
        issue(2'd2, 5'd9, 5'd12, 1'b0, 2'd0);
        collect(1);
    endtask

    initial
    begin
        seed              = 32'h8b37;
        rst               = 1'b1;
        issue_valid       = 1'b0;
        issue_warp        = '0;
        issue_instr       = '0;
        issue_reg_write   = 1'b0;
        issue_imme        = '0;
        issue_imme_valid  = 1'b0;
        issue_alu_op      = op_add;
        issue_mem_write   = 1'b0;
        issue_mem_read    = 1'b0;
        issue_scb_id      = '0;
        issue_active_mask = '0;
        issue_dst         = '0;
        issue_src0        = '0;
        issue_src1        = '0;
        wb_en             = 1'b0;
        wb_warp           = '0;
        wb_reg            = '0;
        wb_data           = '0;
        for (int i = 0; i < num_ids; i++)
            seen[i] = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        test_reset();
        load_registers();
        test_single();
        test_immediate();
        test_same_bank();
        test_full();
        test_write_then_read();
        $display("Verification passed");
        $finish;
    end

endmodule

/* source/bank_arbiter.sv */
`timescale 1ns/10ps

module bank_arbiter (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [oc_pkg::num_cu-1:0]      req,
    input  logic [oc_pkg::num_cu-1:0]      req_bank,
    input  logic [oc_pkg::bank_aw-1:0]     req_addr [oc_pkg::num_cu],
    output logic [oc_pkg::num_cu-1:0]      rd_grant,
    output logic [oc_pkg::num_cu-1:0]      rd_valid,
    output logic [oc_pkg::num_banks-1:0]   rd_en,
    output logic [oc_pkg::bank_aw-1:0]     rd_addr [oc_pkg::num_banks],
    output logic [oc_pkg::num_cu-1:0]      rd_sel [oc_pkg::num_banks]
);
    import oc_pkg::*;

    logic [num_cu-1:0] gnt [num_banks];

    for (genvar b = 0; b < num_banks; b++)
    begin : g_bank
        logic [num_cu-1:0]  cand;
        logic [cu_w-1:0]    ptr;
        logic [num_cu-1:0]  sel_q; // grant delayed to match the read
        logic [bank_aw-1:0] addr;

        assign cand     = req & ~(req_bank ^ {num_cu{1'(b)}});
        assign gnt[b]   = rr_pick(cand, ptr);
        assign rd_en[b] = |gnt[b];

        always_comb
        begin
            addr = '0;
            for (int i = 0; i < num_cu; i++)
            begin
                if (gnt[b][i])
                    addr = req_addr[i];
            end
        end

        always_ff @(posedge clk)
        begin
            if (rst)
            begin
                ptr   <= '0;
                sel_q <= '0;
            end
            else
            begin
                sel_q <= gnt[b];
                if (rd_en[b])
                    ptr <= onehot_idx(gnt[b]) + 1'b1;
            end
        end

        assign rd_addr[b] = addr;
        assign rd_sel[b]  = sel_q;

        a_one_grant: assert property (@(posedge clk) disable iff (rst)
            $onehot0(gnt[b]) && (gnt[b] & ~cand) == '0);
    end

    always_comb
    begin
        rd_grant = '0;
        rd_valid = '0;
        for (int b = 0; b < num_banks; b++)
        begin
            rd_grant = rd_grant | gnt[b];
            rd_valid = rd_valid | rd_sel[b];
        end
    end

endmodule

/* source/collector_unit.sv */
`timescale 1ns/10ps

module collector_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           alloc,
    input  logic [oc_pkg::warp_w-1:0]      issue_warp,
    input  logic [oc_pkg::instr_w-1:0]     issue_instr,
    input  logic                           issue_reg_write,
    input  logic [oc_pkg::imme_w-1:0]      issue_imme,
    input  logic                           issue_imme_valid,
    input  oc_pkg::alu_op_e                issue_alu_op,
    input  logic                           issue_mem_write,
    input  logic                           issue_mem_read,
    input  logic [oc_pkg::scb_w-1:0]       issue_scb_id,
    input  logic [oc_pkg::mask_w-1:0]      issue_active_mask,
    input  logic [oc_pkg::reg_aw-1:0]      issue_dst,
    input  logic [oc_pkg::reg_aw-1:0]      issue_src0,
    input  logic [oc_pkg::reg_aw-1:0]      issue_src1,
    output logic                           free,
    output logic                           ready,
    output logic                           req,
    output logic                           req_bank,
    output logic [oc_pkg::bank_aw-1:0]     req_addr,
    input  logic                           rd_grant,
    input  logic                           rd_valid,
    input  logic [oc_pkg::opnd_w-1:0]      rd_data,
    input  logic                           dispatch,
    output logic [oc_pkg::instr_w-1:0]     instr,
    output logic                           reg_write,
    output logic [oc_pkg::imme_w-1:0]      imme,
    output logic                           imme_valid,
    output oc_pkg::alu_op_e                alu_op,
    output logic                           mem_write,
    output logic                           mem_read,
    output logic [oc_pkg::scb_w-1:0]       scb_id,
    output logic [oc_pkg::mask_w-1:0]      active_mask,
    output logic [oc_pkg::reg_aw-1:0]      dst,
    output logic [oc_pkg::opnd_w-1:0]      oc_0_data,
    output logic [oc_pkg::opnd_w-1:0]      oc_1_data
);
    import oc_pkg::*;

    cu_state_e         state;
    logic              src_sel; // source being fetched
    logic              pend;    // granted, data next cycle
    logic [warp_w-1:0] warp;
    logic [reg_aw-1:0] src0;
    logic [reg_aw-1:0] src1;
    logic [reg_aw-1:0] cur_src;

    assign free     = state == cu_free;
    assign ready    = state == cu_ready;
    assign cur_src  = src_sel ? src1 : src0;
    assign req      = state == cu_fetch && !pend;
    assign req_bank = cur_src[0];
    assign req_addr = {warp, cur_src[reg_aw-1:1]};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= cu_free;
            src_sel <= 1'b0;
            pend    <= 1'b0;
        end
        else
        begin
            case (state)
                cu_free:
                begin
                    src_sel <= 1'b0;
                    pend    <= 1'b0;
                    if (alloc)
                        state <= cu_fetch;
                end
                cu_fetch:
                begin
                    if (rd_grant)
                        pend <= 1'b1;
                    if (rd_valid)
                    begin
                        pend <= 1'b0;
                        if (src_sel || imme_valid) // src1 skipped for immediates
                            state <= cu_ready;
                        else
                            src_sel <= 1'b1;
                    end
                end
                cu_ready:
                    if (dispatch)
                        state <= cu_free;
                default:
                    state <= cu_free;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            warp        <= issue_warp;
            src0        <= issue_src0;
            src1        <= issue_src1;
            instr       <= issue_instr;
            reg_write   <= issue_reg_write;
            imme        <= issue_imme;
            imme_valid  <= issue_imme_valid;
            alu_op      <= issue_alu_op;
            mem_write   <= issue_mem_write;
            mem_read    <= issue_mem_read;
            scb_id      <= issue_scb_id;
            active_mask <= issue_active_mask;
            dst         <= issue_dst;
            oc_1_data   <= '0;
        end
        else if (rd_valid)
        begin
            if (src_sel)
                oc_1_data <= rd_data;
            else
                oc_0_data <= rd_data;
        end
    end

    a_alloc_free: assert property (@(posedge clk) disable iff (rst) alloc |-> free);

endmodule

/* source/dispatch_arbiter.sv */
`timescale 1ns/10ps

module dispatch_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [oc_pkg::num_cu-1:0]  ready,
    output logic [oc_pkg::num_cu-1:0]  grt
);
    import oc_pkg::*;

    logic [cu_w-1:0] ptr;

    assign grt = rr_pick(ready, ptr);

    always_ff @(posedge clk)
    begin
        if (rst)
            ptr <= '0;
        else if (|grt)
            ptr <= onehot_idx(grt) + 1'b1; // skip past the winner
    end

    a_grt_legal: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grt) && (grt & ~ready) == '0);

    // granted slot must leave cu_ready at the next edge
    a_grt_release: assert property (@(posedge clk) disable iff (rst)
        grt != '0 |=> (ready & $past(grt)) == '0);

endmodule

/* source/oc_pkg.sv */
package oc_pkg;

    localparam int num_cu     = 4;
    localparam int num_banks  = 2;
    localparam int num_warps  = 4;
    localparam int lanes      = 8;
    localparam int lane_w     = 32;
    localparam int opnd_w     = lanes * lane_w;
    localparam int reg_aw     = 5;
    localparam int warp_w     = $clog2(num_warps);
    localparam int bank_aw    = warp_w + reg_aw - $clog2(num_banks); // {warp, reg without parity}
    localparam int bank_depth = 2 ** bank_aw;
    localparam int cu_w       = $clog2(num_cu);
    localparam int instr_w    = 32;
    localparam int imme_w     = 16;
    localparam int scb_w      = 2;
    localparam int mask_w     = lanes;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_shl,
        op_shr,
        op_mov
    } alu_op_e;

    typedef enum logic [1:0] {
        cu_free,
        cu_fetch,
        cu_ready
    } cu_state_e;

    // one-hot pick of the first request at or after ptr
    function automatic logic [num_cu-1:0] rr_pick(input logic [num_cu-1:0] req,
                                                  input logic [cu_w-1:0]   ptr);
        logic [cu_w-1:0]   idx;
        logic [num_cu-1:0] gnt;
        gnt = '0;
        for (int k = num_cu - 1; k >= 0; k--)
        begin
            idx = ptr + cu_w'(k); // wraps
            if (req[idx])
                gnt = num_cu'(1) << idx;
        end
        return gnt;
    endfunction

    function automatic logic [cu_w-1:0] onehot_idx(input logic [num_cu-1:0] oh);
        logic [cu_w-1:0] idx;
        idx = '0;
        for (int i = 0; i < num_cu; i++)
        begin
            if (oh[i])
                idx = cu_w'(i);
        end
        return idx;
    endfunction

endpackage

/* source/operand_collector.sv */
`timescale 1ns/10ps

module operand_collector (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           issue_valid,
    input  logic [oc_pkg::warp_w-1:0]      issue_warp,
    input  logic [oc_pkg::instr_w-1:0]     issue_instr,
    input  logic                           issue_reg_write,
    input  logic [oc_pkg::imme_w-1:0]      issue_imme,
    input  logic                           issue_imme_valid,
    input  oc_pkg::alu_op_e                issue_alu_op,
    input  logic                           issue_mem_write,
    input  logic                           issue_mem_read,
    input  logic [oc_pkg::scb_w-1:0]       issue_scb_id,
    input  logic [oc_pkg::mask_w-1:0]      issue_active_mask,
    input  logic [oc_pkg::reg_aw-1:0]      issue_dst,
    input  logic [oc_pkg::reg_aw-1:0]      issue_src0,
    input  logic [oc_pkg::reg_aw-1:0]      issue_src1,
    output logic                           full,
    input  logic                           wb_en,
    input  logic [oc_pkg::warp_w-1:0]      wb_warp,
    input  logic [oc_pkg::reg_aw-1:0]      wb_reg,
    input  logic [oc_pkg::opnd_w-1:0]      wb_data,
    output logic                           ex_valid,
    output logic [oc_pkg::opnd_w-1:0]      oc_0_data,
    output logic [oc_pkg::opnd_w-1:0]      oc_1_data,
    output logic [oc_pkg::instr_w-1:0]     ex_instr,
    output logic                           ex_reg_write,
    output logic [oc_pkg::imme_w-1:0]      ex_imme,
    output logic                           ex_imme_valid,
    output oc_pkg::alu_op_e                ex_alu_op,
    output logic                           ex_mem_write,
    output logic                           ex_mem_read,
    output logic [oc_pkg::scb_w-1:0]       ex_scb_id,
    output logic [oc_pkg::mask_w-1:0]      ex_active_mask,
    output logic [oc_pkg::reg_aw-1:0]      ex_dst
);
    import oc_pkg::*;

    logic [num_cu-1:0]    free;
    logic [num_cu-1:0]    ready;
    logic [num_cu-1:0]    alloc;
    logic [num_cu-1:0]    req;
    logic [num_cu-1:0]    req_bank;
    logic [bank_aw-1:0]   req_addr [num_cu];
    logic [num_cu-1:0]    rd_grant;
    logic [num_cu-1:0]    rd_valid;
    logic [opnd_w-1:0]    cu_rd_data [num_cu];
    logic [num_banks-1:0] rd_en;
    logic [bank_aw-1:0]   rd_addr [num_banks];
    logic [opnd_w-1:0]    rd_data [num_banks];
    logic [num_cu-1:0]    rd_sel [num_banks];
    logic [num_cu-1:0]    grt;

    logic [opnd_w-1:0]    cu_oc_0_data [num_cu];
    logic [opnd_w-1:0]    cu_oc_1_data [num_cu];
    logic [instr_w-1:0]   cu_instr [num_cu];
    logic [num_cu-1:0]    cu_reg_write;
    logic [imme_w-1:0]    cu_imme [num_cu];
    logic [num_cu-1:0]    cu_imme_valid;
    alu_op_e              cu_alu_op [num_cu];
    logic [num_cu-1:0]    cu_mem_write;
    logic [num_cu-1:0]    cu_mem_read;
    logic [scb_w-1:0]     cu_scb_id [num_cu];
    logic [mask_w-1:0]    cu_active_mask [num_cu];
    logic [reg_aw-1:0]    cu_dst [num_cu];

    assign full = ~|free;

    always_comb
    begin
        alloc = '0;
        for (int i = num_cu - 1; i >= 0; i--)
        begin
            if (issue_valid && free[i]) // lowest index wins
                alloc = num_cu'(1) << i;
        end
    end

    // steer each bank's read data to the collector it was read for
    always_comb
    begin
        for (int i = 0; i < num_cu; i++)
        begin
            cu_rd_data[i] = rd_data[0];
            for (int b = 1; b < num_banks; b++)
            begin
                if (rd_sel[b][i])
                    cu_rd_data[i] = rd_data[b];
            end
        end
    end

    register_banks u_register_banks (
        .clk     (clk),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wb_en   (wb_en),
        .wb_warp (wb_warp),
        .wb_reg  (wb_reg),
        .wb_data (wb_data)
    );

    for (genvar i = 0; i < num_cu; i++)
    begin : g_cu
        collector_unit u_collector_unit (
            .clk               (clk),
            .rst               (rst),
            .alloc             (alloc[i]),
            .issue_warp        (issue_warp),
            .issue_instr       (issue_instr),
            .issue_reg_write   (issue_reg_write),
            .issue_imme        (issue_imme),
            .issue_imme_valid  (issue_imme_valid),
            .issue_alu_op      (issue_alu_op),
            .issue_mem_write   (issue_mem_write),
            .issue_mem_read    (issue_mem_read),
            .issue_scb_id      (issue_scb_id),
            .issue_active_mask (issue_active_mask),
            .issue_dst         (issue_dst),
            .issue_src0        (issue_src0),
            .issue_src1        (issue_src1),
            .free              (free[i]),
            .ready             (ready[i]),
            .req               (req[i]),
            .req_bank          (req_bank[i]),
            .req_addr          (req_addr[i]),
            .rd_grant          (rd_grant[i]),
            .rd_valid          (rd_valid[i]),
            .rd_data           (cu_rd_data[i]),
            .dispatch          (grt[i]),
            .instr             (cu_instr[i]),
            .reg_write         (cu_reg_write[i]),
            .imme              (cu_imme[i]),
            .imme_valid        (cu_imme_valid[i]),
            .alu_op            (cu_alu_op[i]),
            .mem_write         (cu_mem_write[i]),
            .mem_read          (cu_mem_read[i]),
            .scb_id            (cu_scb_id[i]),
            .active_mask       (cu_active_mask[i]),
            .dst               (cu_dst[i]),
            .oc_0_data         (cu_oc_0_data[i]),
            .oc_1_data         (cu_oc_1_data[i])
        );
    end

    bank_arbiter u_bank_arbiter (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_bank (req_bank),
        .req_addr (req_addr),
        .rd_grant (rd_grant),
        .rd_valid (rd_valid),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_sel   (rd_sel)
    );

    dispatch_arbiter u_dispatch_arbiter (
        .clk   (clk),
        .rst   (rst),
        .ready (ready),
        .grt   (grt)
    );

    operand_dispatch_mux u_operand_dispatch_mux (
        .grt            (grt),
        .cu_oc_0_data   (cu_oc_0_data),
        .cu_oc_1_data   (cu_oc_1_data),
        .cu_instr       (cu_instr),
        .cu_reg_write   (cu_reg_write),
        .cu_imme        (cu_imme),
        .cu_imme_valid  (cu_imme_valid),
        .cu_alu_op      (cu_alu_op),
        .cu_mem_write   (cu_mem_write),
        .cu_mem_read    (cu_mem_read),
        .cu_scb_id      (cu_scb_id),
        .cu_active_mask (cu_active_mask),
        .cu_dst         (cu_dst),
        .ex_valid       (ex_valid),
        .oc_0_data      (oc_0_data),
        .oc_1_data      (oc_1_data),
        .ex_instr       (ex_instr),
        .ex_reg_write   (ex_reg_write),
        .ex_imme        (ex_imme),
        .ex_imme_valid  (ex_imme_valid),
        .ex_alu_op      (ex_alu_op),
        .ex_mem_write   (ex_mem_write),
        .ex_mem_read    (ex_mem_read),
        .ex_scb_id      (ex_scb_id),
        .ex_active_mask (ex_active_mask),
        .ex_dst         (ex_dst)
    );

    a_issue_not_full: assert property (@(posedge clk) disable iff (rst) issue_valid |-> !full);

endmodule

/* source/operand_dispatch_mux.sv */
`timescale 1ns/10ps

module operand_dispatch_mux (
    input  logic [oc_pkg::num_cu-1:0]      grt,
    input  logic [oc_pkg::opnd_w-1:0]      cu_oc_0_data [oc_pkg::num_cu],
    input  logic [oc_pkg::opnd_w-1:0]      cu_oc_1_data [oc_pkg::num_cu],
    input  logic [oc_pkg::instr_w-1:0]     cu_instr [oc_pkg::num_cu],
    input  logic [oc_pkg::num_cu-1:0]      cu_reg_write,
    input  logic [oc_pkg::imme_w-1:0]      cu_imme [oc_pkg::num_cu],
    input  logic [oc_pkg::num_cu-1:0]      cu_imme_valid,
    input  oc_pkg::alu_op_e                cu_alu_op [oc_pkg::num_cu],
    input  logic [oc_pkg::num_cu-1:0]      cu_mem_write,
    input  logic [oc_pkg::num_cu-1:0]      cu_mem_read,
    input  logic [oc_pkg::scb_w-1:0]       cu_scb_id [oc_pkg::num_cu],
    input  logic [oc_pkg::mask_w-1:0]      cu_active_mask [oc_pkg::num_cu],
    input  logic [oc_pkg::reg_aw-1:0]      cu_dst [oc_pkg::num_cu],
    output logic                           ex_valid,
    output logic [oc_pkg::opnd_w-1:0]      oc_0_data,
    output logic [oc_pkg::opnd_w-1:0]      oc_1_data,
    output logic [oc_pkg::instr_w-1:0]     ex_instr,
    output logic                           ex_reg_write,
    output logic [oc_pkg::imme_w-1:0]      ex_imme,
    output logic                           ex_imme_valid,
    output oc_pkg::alu_op_e                ex_alu_op,
    output logic                           ex_mem_write,
    output logic                           ex_mem_read,
    output logic [oc_pkg::scb_w-1:0]       ex_scb_id,
    output logic [oc_pkg::mask_w-1:0]      ex_active_mask,
    output logic [oc_pkg::reg_aw-1:0]      ex_dst
);
    import oc_pkg::*;

    logic [cu_w-1:0] sel;

    assign ex_valid = |grt;

    always_comb
    begin
        case (grt)
            4'b0001: sel = 2'd0;
            4'b0010: sel = 2'd1;
            4'b0100: sel = 2'd2;
            default: sel = 2'd3; // also the idle value
        endcase
    end

    assign oc_0_data      = cu_oc_0_data[sel];
    assign oc_1_data      = cu_oc_1_data[sel];
    assign ex_instr       = cu_instr[sel];
    assign ex_reg_write   = cu_reg_write[sel];
    assign ex_imme        = cu_imme[sel];
    assign ex_imme_valid  = cu_imme_valid[sel];
    assign ex_alu_op      = cu_alu_op[sel];
    assign ex_mem_write   = cu_mem_write[sel];
    assign ex_mem_read    = cu_mem_read[sel];
    assign ex_scb_id      = cu_scb_id[sel];
    assign ex_active_mask = cu_active_mask[sel];
    assign ex_dst         = cu_dst[sel];

endmodule

/* source/register_banks.sv */
`timescale 1ns/10ps

module register_banks (
    input  logic                           clk,
    input  logic [oc_pkg::num_banks-1:0]   rd_en,
    input  logic [oc_pkg::bank_aw-1:0]     rd_addr [oc_pkg::num_banks],
    output logic [oc_pkg::opnd_w-1:0]      rd_data [oc_pkg::num_banks],
    input  logic                           wb_en,
    input  logic [oc_pkg::warp_w-1:0]      wb_warp,
    input  logic [oc_pkg::reg_aw-1:0]      wb_reg,
    input  logic [oc_pkg::opnd_w-1:0]      wb_data
);
    import oc_pkg::*;

    for (genvar b = 0; b < num_banks; b++)
    begin : g_bank
        logic [opnd_w-1:0] mem [bank_depth];
        logic [opnd_w-1:0] dout;

        always_ff @(posedge clk)
        begin
            if (wb_en && wb_reg[0] == 1'(b)) // parity picks the bank
                mem[{wb_warp, wb_reg[reg_aw-1:1]}] <= wb_data;
            if (rd_en[b])
                dout <= mem[rd_addr[b]]; // old value on same-cycle write
        end

        assign rd_data[b] = dout;
    end

endmodule

/* tb.f */
source/oc_pkg.sv
source/register_banks.sv
source/collector_unit.sv
source/bank_arbiter.sv
source/dispatch_arbiter.sv
source/operand_dispatch_mux.sv
source/operand_collector.sv
dv/tb_operand_collector.sv
